// ==== files.f ====
+incdir+testbench
source/alu_pkg.sv
source/issue_register.sv
source/alu.sv
source/complete_register.sv
source/alu_cluster.sv
testbench/alu_cluster_tb.sv

// ==== Makefile ====
# Verilator build and run of the ALU cluster testbench

VERILATOR ?= verilator
TOP       ?= alu_cluster_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
SIM_EXE   ?= V$(TOP)

.PHONY: sim clean

# a $fatal in the testbench makes the run exit non-zero
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o $(SIM_EXE)
	./$(BUILD_DIR)/$(SIM_EXE)

clean:
	rm -rf $(BUILD_DIR)

// ==== testbench/alu_model.svh ====
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// shadow pipeline, one entry per stage
logic          exp_issue_valid;
issue_packet_t exp_issue_pack;
logic          exp_alu_valid;
fu_packet_t    exp_alu_pack;
logic          exp_result_valid;
fu_packet_t    exp_result_pack;

// sign extension from a field of the given width
function automatic data_t sign_extend(input data_t value, input int width);
    data_t fill;
    fill = ~(data_t'(0)) << width;
    return value[width-1] ? (value | fill) : (value & ~fill);
endfunction

function automatic data_t select_opa(input issue_packet_t p);
    case (p.opa_sel)
        OPA_IS_RS1: return p.rs1_value;
        OPA_IS_NPC: return p.npc;
        OPA_IS_PC:  return p.pc;
        default:    return '0;
    endcase
endfunction

// immediates rebuilt from the RV32I instruction formats
function automatic data_t select_opb(input issue_packet_t p);
    case (p.opb_sel)
        OPB_IS_RS2:   return p.rs2_value;
        OPB_IS_I_IMM: return sign_extend(p.inst >> 20, 12);
        OPB_IS_S_IMM: return sign_extend({20'b0, p.inst[31:25], p.inst[11:7]}, 12);
        OPB_IS_B_IMM: return sign_extend({19'b0, p.inst[31], p.inst[7], p.inst[30:25],
                                          p.inst[11:8], 1'b0}, 13);
        OPB_IS_U_IMM: return p.inst & 32'hffff_f000;
        OPB_IS_J_IMM: return sign_extend({11'b0, p.inst[31], p.inst[19:12], p.inst[20],
                                          p.inst[30:21], 1'b0}, 21);
        default:      return '0;
    endcase
endfunction

function automatic data_t compute_result(input alu_func_e func, input data_t a, input data_t b);
    logic [4:0] sh;
    logic       lt;
    sh = b[4:0];
    // signed less-than from the sign bits
    lt = (a[31] != b[31]) ? a[31] : (a < b);
    case (func)
        ALU_ADD:  return a + b;
        ALU_SUB:  return a + ~b + 32'd1;
        ALU_AND:  return a & b;
        ALU_OR:   return a | b;
        ALU_XOR:  return a ^ b;
        ALU_SLT:  return lt ? 32'd1 : 32'd0;
        ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
        ALU_SLL:  return a << sh;
        ALU_SRL:  return a >> sh;
        ALU_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
        default:  return '0;
    endcase
endfunction

function automatic fu_packet_t complete_packet(input issue_packet_t p);
    fu_packet_t f;
    f.result   = compute_result(p.alu_func, select_opa(p), select_opb(p));
    f.pc       = p.pc;
    f.dest_tag = p.dest_tag;
    f.b_mask   = p.b_mask;
    return f;
endfunction

// squash kills on any shared bit, clear drops the resolved bit
task automatic resolve_branch(inout logic valid, inout br_mask_t mask,
                              input br_task_e action, input br_mask_t id);
    for (int i = 0; i < BR_MASK_W; i++) begin
        if (id[i]) begin
            if (action == BR_SQUASH && mask[i]) begin
                valid = 1'b0;
            end
            if (action == BR_CLEAR) begin
                mask[i] = 1'b0;
            end
        end
    end
endtask

task automatic reset_pipeline();
    exp_issue_valid  = 1'b0;
    exp_issue_pack   = '0;
    exp_alu_valid    = 1'b0;
    exp_alu_pack     = '0;
    exp_result_valid = 1'b0;
    exp_result_pack  = '0;
endtask

task automatic advance_pipeline(input logic stall_in, input logic valid_in,
                                input issue_packet_t pack_in, input br_task_e action,
                                input br_mask_t id);
    logic          v0;
    logic          v1;
    logic          v2;
    issue_packet_t p0;
    fu_packet_t    p1;
    fu_packet_t    p2;
    br_mask_t      m;
    if (stall_in) begin
        v0 = exp_issue_valid;
        p0 = exp_issue_pack;
        v1 = exp_alu_valid;
        p1 = exp_alu_pack;
        v2 = exp_result_valid;
        p2 = exp_result_pack;
    end else begin
        v0 = valid_in;
        p0 = pack_in;
        v1 = exp_issue_valid;
        p1 = complete_packet(exp_issue_pack);
        v2 = exp_alu_valid;
        p2 = exp_alu_pack;
    end
    m = p0.b_mask;
    resolve_branch(v0, m, action, id);
    p0.b_mask = m;
    m = p1.b_mask;
    resolve_branch(v1, m, action, id);
    p1.b_mask = m;
    m = p2.b_mask;
    resolve_branch(v2, m, action, id);
    p2.b_mask = m;
    // dead entries read as zero
    exp_issue_valid  = v0;
    exp_issue_pack   = v0 ? p0 : '0;
    exp_alu_valid    = v1;
    exp_alu_pack     = v1 ? p1 : '0;
    exp_result_valid = v2;
    exp_result_pack  = v2 ? p2 : '0;
endtask

`endif

// ==== testbench/alu_cluster_tb.sv ====
`timescale 1ns/100ps

module alu_cluster_tb;
    import alu_pkg::*;

    localparam int NUM_CYCLES     = 600;
    localparam int DRAIN_CYCLES   = 4;
    localparam int TIMEOUT_CYCLES = 2000 + NUM_CYCLES + DRAIN_CYCLES;

    logic          clock;
    logic          rst_n;
    logic          issue_valid;
    issue_packet_t issue_pack;
    logic          stall;
    br_task_e      br_task;
    br_mask_t      br_id;
    logic          result_valid;
    fu_packet_t    result_pack;

    int            cycle_count = 0;
    int            results_seen;
    logic          prev_valid;
    fu_packet_t    prev_pack;

    `include "alu_model.svh"

    alu_cluster u_dut (
        .clock        (clock),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_pack   (issue_pack),
        .stall        (stall),
        .br_task      (br_task),
        .br_id        (br_id),
        .result_valid (result_valid),
        .result_pack  (result_pack)
    );

    initial clock = 1'b0;
    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("TESTS FAILED");
            $fatal(1, "run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    task automatic check_valid(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %b, actual %b", $time, name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_pack(input string name, input fu_packet_t expected,
                              input fu_packet_t actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %h, actual %h", $time, name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic drive_random_inputs();
        int unsigned   pick;
        issue_packet_t pack;
        pick = $urandom % 100;
        stall = (pick < 15);
        pack.inst      = $urandom;
        pack.pc        = $urandom & 32'hffff_fffc;
        pack.npc       = pack.pc + 32'd4;
        pack.opa_sel   = opa_sel_e'(2'($urandom % 4));
        pack.opb_sel   = opb_sel_e'(3'($urandom % 6));
        pack.alu_func  = alu_func_e'(4'($urandom % 10));
        pack.dest_tag  = tag_t'($urandom);
        pack.b_mask    = br_mask_t'($urandom);
        pack.rs1_value = $urandom;
        // equal operands now and then for the compares
        pack.rs2_value = (($urandom % 10) == 0) ? pack.rs1_value : $urandom;
        issue_pack = pack;
        // a strobe under stall must be ignored
        issue_valid = stall ? (($urandom % 100) < 5) : (($urandom % 100) < 70);
        pick = $urandom % 100;
        if (pick < 10) begin
            br_task = BR_SQUASH;
        end else if (pick < 22) begin
            br_task = BR_CLEAR;
        end else begin
            br_task = BR_NONE;
        end
        br_id = br_mask_t'(4'b0001 << ($urandom % BR_MASK_W));
    endtask

    task automatic drive_idle();
        issue_valid = 1'b0;
        issue_pack  = '0;
        stall       = 1'b0;
        br_task     = BR_NONE;
        br_id       = '0;
    endtask

    // one clock of DUT and model, then compare
    task automatic run_cycle();
        prev_valid = result_valid;
        prev_pack  = result_pack;
        @(posedge clock);
        advance_pipeline(stall, issue_valid, issue_pack, br_task, br_id);
        #1;
        check_valid("result_valid", exp_result_valid, result_valid);
        check_pack("result_pack", exp_result_pack, result_pack);
        if (stall && br_task == BR_NONE) begin
            check_valid("result_valid during stall", prev_valid, result_valid);
            check_pack("result_pack during stall", prev_pack, result_pack);
        end
        if (exp_result_valid) begin
            results_seen++;
        end
    endtask

    initial begin
        void'($urandom(60));
        results_seen = 0;
        rst_n = 1'b0;
        drive_idle();
        reset_pipeline();
        repeat (3) @(posedge clock);
        #1;
        check_valid("result_valid after reset", 1'b0, result_valid);
        check_pack("result_pack after reset", '0, result_pack);
        rst_n = 1'b1;
        for (int i = 0; i < NUM_CYCLES; i++) begin
            drive_random_inputs();
            run_cycle();
        end
        // let the last items leave the pipe
        for (int i = 0; i < DRAIN_CYCLES; i++) begin
            drive_idle();
            run_cycle();
        end
        if (results_seen == 0) begin
            $display("TESTS FAILED");
            $fatal(1, "no result ever completed");
        end else begin
            $display("%0d results compared", results_seen);
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== source/alu_cluster.sv ====
`timescale 1ns/100ps

module alu_cluster (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   issue_valid,
    input  alu_pkg::issue_packet_t issue_pack,
    input  logic                   stall,
    input  alu_pkg::br_task_e      br_task,
    input  alu_pkg::br_mask_t      br_id,
    output logic                   result_valid,
    output alu_pkg::fu_packet_t    result_pack
);
    import alu_pkg::*;

    // issue stage to compute stage
    logic          issue_register_valid;
    issue_packet_t issue_register_pack;

    // compute stage to completion stage
    logic          alu_valid;
    fu_packet_t    alu_pack;

    issue_register u_issue (
        .clock       (clock),
        .rst_n       (rst_n),
        .stall       (stall),
        .issue_valid (issue_valid),
        .issue_pack  (issue_pack),
        .br_task     (br_task),
        .br_id       (br_id),
        .out_valid   (issue_register_valid),
        .out_pack    (issue_register_pack)
    );

    alu u_alu (
        .clock     (clock),
        .rst_n     (rst_n),
        .stall     (stall),
        .in_valid  (issue_register_valid),
        .in_pack   (issue_register_pack),
        .br_task   (br_task),
        .br_id     (br_id),
        .out_valid (alu_valid),
        .out_pack  (alu_pack)
    );

    // result packets leave here for writeback and the CDB
    complete_register u_complete (
        .clock        (clock),
        .rst_n        (rst_n),
        .stall        (stall),
        .in_valid     (alu_valid),
        .in_pack      (alu_pack),
        .br_task      (br_task),
        .br_id        (br_id),
        .result_valid (result_valid),
        .result_pack  (result_pack)
    );

endmodule

// ==== source/complete_register.sv ====
`timescale 1ns/100ps

module complete_register (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                stall,
    input  logic                in_valid,
    input  alu_pkg::fu_packet_t in_pack,
    input  alu_pkg::br_task_e   br_task,
    input  alu_pkg::br_mask_t   br_id,
    output logic                result_valid,
    output alu_pkg::fu_packet_t result_pack
);
    import alu_pkg::*;

    logic       cand_valid;
    fu_packet_t cand_pack;
    logic       next_valid;
    fu_packet_t next_pack;

    // the writeback bus keeps seeing the held result during a stall
    always_comb begin
        if (stall) begin
            cand_valid = result_valid;
            cand_pack  = result_pack;
        end else begin
            cand_valid = in_valid;
            cand_pack  = in_pack;
        end
    end

    // squash and clear on the arriving or the held packet
    always_comb begin
        next_valid       = cand_valid && !mask_squashed(cand_pack.b_mask, br_task, br_id);
        next_pack        = cand_pack;
        next_pack.b_mask = mask_after_clear(cand_pack.b_mask, br_task, br_id);
        if (!next_valid) begin
            next_pack = '0;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            result_pack  <= '0;
        end else begin
            result_valid <= next_valid;
            result_pack  <= next_pack;
        end
    end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/100ps

module alu (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   stall,
    input  logic                   in_valid,
    input  alu_pkg::issue_packet_t in_pack,
    input  alu_pkg::br_task_e      br_task,
    input  alu_pkg::br_mask_t      br_id,
    output logic                   out_valid,
    output alu_pkg::fu_packet_t    out_pack
);
    import alu_pkg::*;

    data_t      opa;
    data_t      opb;
    data_t      result;
    fu_packet_t comp_pack;
    logic       cand_valid;
    fu_packet_t cand_pack;
    logic       next_valid;
    fu_packet_t next_pack;

    // operand A source
    always_comb begin
        case (in_pack.opa_sel)
            OPA_IS_RS1:  opa = in_pack.rs1_value;
            OPA_IS_NPC:  opa = in_pack.npc;
            OPA_IS_PC:   opa = in_pack.pc;
            OPA_IS_ZERO: opa = '0;
            default:     opa = '0;
        endcase
    end

    // operand B is rs2 or one of the immediates
    always_comb begin
        case (in_pack.opb_sel)
            OPB_IS_RS2:   opb = in_pack.rs2_value;
            OPB_IS_I_IMM: opb = imm_i(in_pack.inst);
            OPB_IS_S_IMM: opb = imm_s(in_pack.inst);
            OPB_IS_B_IMM: opb = imm_b(in_pack.inst);
            OPB_IS_U_IMM: opb = imm_u(in_pack.inst);
            OPB_IS_J_IMM: opb = imm_j(in_pack.inst);
            default:      opb = '0;
        endcase
    end

    always_comb begin
        case (in_pack.alu_func)
            ALU_ADD: begin
                result = opa + opb;
            end
            ALU_SUB: begin
                result = opa - opb;
            end
            ALU_AND: begin
                result = opa & opb;
            end
            ALU_OR: begin
                result = opa | opb;
            end
            ALU_XOR: begin
                result = opa ^ opb;
            end
            ALU_SLT: begin
                result = {{(DATA_W-1){1'b0}}, (signed'(opa) < signed'(opb))};
            end
            ALU_SLTU: begin
                result = {{(DATA_W-1){1'b0}}, (opa < opb)};
            end
            ALU_SLL: begin
                result = opa << opb[SHAMT_W-1:0];
            end
            ALU_SRL: begin
                result = opa >> opb[SHAMT_W-1:0];
            end
            ALU_SRA: begin
                // sign bit fills from the left
                result = signed'(opa) >>> opb[SHAMT_W-1:0];
            end
            default: begin
                result = '0;
            end
        endcase
    end

    always_comb begin
        comp_pack.result   = result;
        comp_pack.pc       = in_pack.pc;
        comp_pack.dest_tag = in_pack.dest_tag;
        comp_pack.b_mask   = in_pack.b_mask;
    end

    // hold the computed packet while stalled
    always_comb begin
        if (stall) begin
            cand_valid = out_valid;
            cand_pack  = out_pack;
        end else begin
            cand_valid = in_valid;
            cand_pack  = comp_pack;
        end
    end

    always_comb begin
        next_valid       = cand_valid && !mask_squashed(cand_pack.b_mask, br_task, br_id);
        next_pack        = cand_pack;
        next_pack.b_mask = mask_after_clear(cand_pack.b_mask, br_task, br_id);
        if (!next_valid) begin
            next_pack = '0;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_pack  <= '0;
        end else begin
            out_valid <= next_valid;
            out_pack  <= next_pack;
        end
    end

endmodule

// ==== source/issue_register.sv ====
`timescale 1ns/100ps

module issue_register (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   stall,
    input  logic                   issue_valid,
    input  alu_pkg::issue_packet_t issue_pack,
    input  alu_pkg::br_task_e      br_task,
    input  alu_pkg::br_mask_t      br_id,
    output logic                   out_valid,
    output alu_pkg::issue_packet_t out_pack
);
    import alu_pkg::*;

    logic          cand_valid;
    issue_packet_t cand_pack;
    logic          next_valid;
    issue_packet_t next_pack;

    // under stall the held item stays and a new strobe is dropped
    always_comb begin
        if (stall) begin
            cand_valid = out_valid;
            cand_pack  = out_pack;
        end else begin
            cand_valid = issue_valid;
            cand_pack  = issue_pack;
        end
    end

    // branch resolution on whichever item is about to be held
    always_comb begin
        next_valid       = cand_valid && !mask_squashed(cand_pack.b_mask, br_task, br_id);
        next_pack        = cand_pack;
        next_pack.b_mask = mask_after_clear(cand_pack.b_mask, br_task, br_id);
        if (!next_valid) begin
            next_pack = '0;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_pack  <= '0;
        end else begin
            out_valid <= next_valid;
            out_pack  <= next_pack;
        end
    end

endmodule

// ==== source/alu_pkg.sv ====
package alu_pkg;

    // machine-wide widths
    localparam int DATA_W    = 32;
    localparam int BR_MASK_W = 4;
    localparam int TAG_W     = 6;
    // RV32I shift amount field
    localparam int SHAMT_W   = 5;

    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [DATA_W-1:0]    inst_t;
    typedef logic [DATA_W-1:0]    pc_t;
    typedef logic [BR_MASK_W-1:0] br_mask_t;
    typedef logic [TAG_W-1:0]     tag_t;

    // branch resolution broadcast
    typedef enum logic [1:0] {
        BR_NONE   = 2'd0,
        BR_CLEAR  = 2'd1,
        BR_SQUASH = 2'd2
    } br_task_e;

    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'd0,
        OPA_IS_NPC  = 2'd1,
        OPA_IS_PC   = 2'd2,
        OPA_IS_ZERO = 2'd3
    } opa_sel_e;

    typedef enum logic [2:0] {
        OPB_IS_RS2   = 3'd0,
        OPB_IS_I_IMM = 3'd1,
        OPB_IS_S_IMM = 3'd2,
        OPB_IS_B_IMM = 3'd3,
        OPB_IS_U_IMM = 3'd4,
        OPB_IS_J_IMM = 3'd5
    } opb_sel_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_func_e;

    // issued instruction with its source operands already read
    typedef struct packed {
        inst_t     inst;
        pc_t       pc;
        pc_t       npc;
        opa_sel_e  opa_sel;
        opb_sel_e  opb_sel;
        alu_func_e alu_func;
        tag_t      dest_tag;
        br_mask_t  b_mask;
        data_t     rs1_value;
        data_t     rs2_value;
    } issue_packet_t;

    // completed result toward writeback and the CDB
    typedef struct packed {
        data_t    result;
        pc_t      pc;
        tag_t     dest_tag;
        br_mask_t b_mask;
    } fu_packet_t;

    // sign-extended immediates of the RV32I formats
    function automatic data_t imm_i(input inst_t inst);
        return {{20{inst[31]}}, inst[31:20]};
    endfunction

    function automatic data_t imm_s(input inst_t inst);
        return {{20{inst[31]}}, inst[31:25], inst[11:7]};
    endfunction

    function automatic data_t imm_b(input inst_t inst);
        return {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

    function automatic data_t imm_u(input inst_t inst);
        return {inst[31:12], 12'b0};
    endfunction

    function automatic data_t imm_j(input inst_t inst);
        return {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

    // true when a squash hits an item carrying this mask
    function automatic logic mask_squashed(input br_mask_t mask, input br_task_e br_task,
                                           input br_mask_t br_id);
        return (br_task == BR_SQUASH) && ((mask & br_id) != '0);
    endfunction

    // resolved branch bit drops out of the mask
    function automatic br_mask_t mask_after_clear(input br_mask_t mask, input br_task_e br_task,
                                                  input br_mask_t br_id);
        return (br_task == BR_CLEAR) ? (mask & ~br_id) : mask;
    endfunction

endpackage
